//--- verilog/bp_pkg.sv
package bp_pkg;

    // fetch group and resolution width
    localparam int fetch_width = 2;

    localparam int addr_bits = 32;

    // instruction address, bits 1:0 always zero
    typedef logic [addr_bits-1:0] addr_t;

    // branch target buffer geometry
    localparam int btb_index_bits = 4;
    localparam int btb_size       = 2 ** btb_index_bits;
    localparam int btb_tag_bits   = addr_bits - btb_index_bits - 2;

    // local predictor geometry
    localparam int bht_index_bits = 4;
    localparam int bht_size       = 2 ** bht_index_bits;
    localparam int bht_width      = 4;
    localparam int local_pht_size = 2 ** bht_width;

    // gshare geometry, history folds into the top index bits
    localparam int gshare_pc_bits   = 5;
    localparam int gshare_hist_bits = 3;
    localparam int gshare_pht_size  = 2 ** gshare_pc_bits;

    // chooser bias, reset value favors local
    localparam int bias_bits = 2;
    localparam logic [bias_bits-1:0] bias_reset_value = 3;

    // one-bit pattern state
    typedef enum logic {
        not_taken = 1'b0,
        taken     = 1'b1
    } pht_state_t;

    typedef struct packed {
        logic                    valid;
        logic [btb_tag_bits-1:0] tag;
        addr_t                   target;
    } btb_entry_t;

endpackage

//--- verilog/btb.sv
`timescale 1ns/100ps

module btb (
    input  logic                                         clock,
    input  logic                                         reset,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0]      lookup_pc,
    input  logic          [bp_pkg::fetch_width-1:0]      resolve_valid,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0]      resolve_pc,
    input  logic          [bp_pkg::fetch_width-1:0]      resolve_taken,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0]      resolve_target,
    output logic          [bp_pkg::fetch_width-1:0]      hit,
    output bp_pkg::addr_t [bp_pkg::fetch_width-1:0]      target
);

    bp_pkg::btb_entry_t [bp_pkg::btb_size-1:0] entries;
    bp_pkg::btb_entry_t [bp_pkg::btb_size-1:0] entries_next;

    logic [bp_pkg::fetch_width-1:0][bp_pkg::btb_index_bits-1:0] lookup_index;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::btb_tag_bits-1:0]   lookup_tag;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::btb_index_bits-1:0] resolve_index;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::btb_tag_bits-1:0]   resolve_tag;

    for (genvar i = 0; i < bp_pkg::fetch_width; i++) begin : g_port
        assign lookup_index[i]  = lookup_pc[i][bp_pkg::btb_index_bits+1:2];
        assign lookup_tag[i]    = lookup_pc[i][bp_pkg::addr_bits-1:bp_pkg::btb_index_bits+2];
        assign resolve_index[i] = resolve_pc[i][bp_pkg::btb_index_bits+1:2];
        assign resolve_tag[i]   = resolve_pc[i][bp_pkg::addr_bits-1:bp_pkg::btb_index_bits+2];

        assign hit[i] = entries[lookup_index[i]].valid &&
                        (entries[lookup_index[i]].tag == lookup_tag[i]);
        // target comes out even on a miss
        assign target[i] = entries[lookup_index[i]].target;
    end

    // later slots overwrite earlier ones on a shared index
    always_comb begin
        entries_next = entries;
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            if (resolve_valid[i] && resolve_taken[i]) begin
                entries_next[resolve_index[i]].valid  = 1'b1;
                entries_next[resolve_index[i]].tag    = resolve_tag[i];
                entries_next[resolve_index[i]].target = resolve_target[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < bp_pkg::btb_size; j++) begin
                entries[j].valid <= 1'b0;
            end
        end else begin
            entries <= entries_next;
        end
    end

    hit_known: assert property (
        @(posedge clock) disable iff (reset) !$isunknown(hit)
    ) else $error("btb hit is unknown");

endmodule

//--- verilog/local_predictor.sv
`timescale 1ns/100ps

module local_predictor (
    input  logic                                    clock,
    input  logic                                    reset,
    input  bp_pkg::addr_t                           pc_start,
    input  logic          [bp_pkg::fetch_width-1:0] resolve_valid,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0] resolve_pc,
    input  logic          [bp_pkg::fetch_width-1:0] resolve_taken,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0] resolve_target,
    output logic          [bp_pkg::fetch_width-1:0] slot_taken,
    output bp_pkg::addr_t [bp_pkg::fetch_width-1:0] slot_pc,
    output logic          [bp_pkg::fetch_width-1:0] correct
);

    // per-branch history and the pattern table it selects into
    logic [bp_pkg::bht_size-1:0][bp_pkg::bht_width-1:0] bht;
    logic [bp_pkg::bht_size-1:0][bp_pkg::bht_width-1:0] bht_next;
    bp_pkg::pht_state_t [bp_pkg::local_pht_size-1:0]    pht;
    bp_pkg::pht_state_t [bp_pkg::local_pht_size-1:0]    pht_next;

    bp_pkg::addr_t [bp_pkg::fetch_width-1:0]                      lookup_pc;
    logic          [bp_pkg::fetch_width-1:0]                      hit;
    bp_pkg::addr_t [bp_pkg::fetch_width-1:0]                      target;
    logic          [bp_pkg::fetch_width-1:0][bp_pkg::bht_index_bits-1:0] lookup_index;
    logic          [bp_pkg::fetch_width-1:0][bp_pkg::bht_index_bits-1:0] resolve_index;

    btb target_buffer (
        .clock          (clock),
        .reset          (reset),
        .lookup_pc      (lookup_pc),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .hit            (hit),
        .target         (target)
    );

    for (genvar i = 0; i < bp_pkg::fetch_width; i++) begin : g_slot
        // each slot fetches from where the previous one predicted
        if (i == 0) begin : g_first
            assign lookup_pc[i] = pc_start;
        end else begin : g_chain
            assign lookup_pc[i] = slot_pc[i-1];
        end

        assign lookup_index[i]  = lookup_pc[i][bp_pkg::bht_index_bits+1:2];
        assign resolve_index[i] = resolve_pc[i][bp_pkg::bht_index_bits+1:2];

        assign slot_taken[i] = (pht[bht[lookup_index[i]]] == bp_pkg::taken) && hit[i];
        assign slot_pc[i]    = slot_taken[i] ? target[i] : lookup_pc[i] + 32'd4;

        slot_pc_aligned: assert property (
            @(posedge clock) disable iff (reset) slot_pc[i][1:0] == 2'b00
        ) else $error("local slot %0d pc misaligned", i);
    end

    // pattern index uses the history as it stood at the start of the cycle
    always_comb begin
        bht_next = bht;
        pht_next = pht;
        correct  = '0;
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            if (resolve_valid[i]) begin
                bht_next[resolve_index[i]] = {
                    bht_next[resolve_index[i]][bp_pkg::bht_width-2:0],
                    resolve_taken[i]
                };
                pht_next[bht[resolve_index[i]]] =
                    resolve_taken[i] ? bp_pkg::taken : bp_pkg::not_taken;
                correct[i] = (pht[bht[resolve_index[i]]] == bp_pkg::taken) == resolve_taken[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bht <= '0;
            // odd entries start out taken
            for (int j = 0; j < bp_pkg::local_pht_size; j++) begin
                pht[j] <= j[0] ? bp_pkg::taken : bp_pkg::not_taken;
            end
        end else begin
            bht <= bht_next;
            pht <= pht_next;
        end
    end

endmodule

//--- verilog/gshare_predictor.sv
`timescale 1ns/100ps

module gshare_predictor (
    input  logic                                    clock,
    input  logic                                    reset,
    input  bp_pkg::addr_t                           pc_start,
    input  logic          [bp_pkg::fetch_width-1:0] resolve_valid,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0] resolve_pc,
    input  logic          [bp_pkg::fetch_width-1:0] resolve_taken,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0] resolve_target,
    output logic          [bp_pkg::fetch_width-1:0] slot_taken,
    output bp_pkg::addr_t [bp_pkg::fetch_width-1:0] slot_pc,
    output logic          [bp_pkg::fetch_width-1:0] correct
);

    // xor history into the top bits of the address index
    function automatic logic [bp_pkg::gshare_pc_bits-1:0] hash_index(
        input bp_pkg::addr_t                        pc,
        input logic [bp_pkg::gshare_hist_bits-1:0]  history
    );
        logic [bp_pkg::gshare_pc_bits-1:0] raw;
        raw = pc[bp_pkg::gshare_pc_bits+1:2];
        return {
            raw[bp_pkg::gshare_pc_bits-1 -: bp_pkg::gshare_hist_bits] ^ history,
            raw[bp_pkg::gshare_pc_bits-bp_pkg::gshare_hist_bits-1:0]
        };
    endfunction

    logic [bp_pkg::gshare_hist_bits-1:0]              ghist;
    logic [bp_pkg::gshare_hist_bits-1:0]              ghist_next;
    bp_pkg::pht_state_t [bp_pkg::gshare_pht_size-1:0] pht;
    bp_pkg::pht_state_t [bp_pkg::gshare_pht_size-1:0] pht_next;

    bp_pkg::addr_t [bp_pkg::fetch_width-1:0]                      lookup_pc;
    logic          [bp_pkg::fetch_width-1:0]                      hit;
    bp_pkg::addr_t [bp_pkg::fetch_width-1:0]                      target;
    logic          [bp_pkg::fetch_width-1:0][bp_pkg::gshare_pc_bits-1:0] lookup_index;
    logic          [bp_pkg::fetch_width-1:0][bp_pkg::gshare_pc_bits-1:0] resolve_index;

    btb target_buffer (
        .clock          (clock),
        .reset          (reset),
        .lookup_pc      (lookup_pc),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .hit            (hit),
        .target         (target)
    );

    for (genvar i = 0; i < bp_pkg::fetch_width; i++) begin : g_slot
        if (i == 0) begin : g_first
            assign lookup_pc[i] = pc_start;
        end else begin : g_chain
            assign lookup_pc[i] = slot_pc[i-1];
        end

        assign lookup_index[i]  = hash_index(lookup_pc[i], ghist);
        // pre-update history for every report of the cycle
        assign resolve_index[i] = hash_index(resolve_pc[i], ghist);

        assign slot_taken[i] = (pht[lookup_index[i]] == bp_pkg::taken) && hit[i];
        assign slot_pc[i]    = slot_taken[i] ? target[i] : lookup_pc[i] + 32'd4;
    end

    always_comb begin
        ghist_next = ghist;
        pht_next   = pht;
        correct    = '0;
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            if (resolve_valid[i]) begin
                // outcomes enter the history in slot order
                ghist_next = {ghist_next[bp_pkg::gshare_hist_bits-2:0], resolve_taken[i]};
                pht_next[resolve_index[i]] =
                    resolve_taken[i] ? bp_pkg::taken : bp_pkg::not_taken;
                correct[i] = (pht[resolve_index[i]] == bp_pkg::taken) == resolve_taken[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ghist <= '0;
            pht   <= '0;
        end else begin
            ghist <= ghist_next;
            pht   <= pht_next;
        end
    end

endmodule

//--- verilog/predictor_chooser.sv
`timescale 1ns/100ps

module predictor_chooser (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic          [bp_pkg::fetch_width-1:0] resolve_valid,
    input  logic          [bp_pkg::fetch_width-1:0] local_taken,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0] local_pc,
    input  logic          [bp_pkg::fetch_width-1:0] local_correct,
    input  logic          [bp_pkg::fetch_width-1:0] global_taken,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0] global_pc,
    input  logic          [bp_pkg::fetch_width-1:0] global_correct,
    output logic          [bp_pkg::fetch_width-1:0] pred_taken,
    output bp_pkg::addr_t [bp_pkg::fetch_width-1:0] pred_pc
);

    localparam logic [bp_pkg::bias_bits-1:0] bias_max = '1;

    logic [bp_pkg::bias_bits-1:0] bias;
    logic [bp_pkg::bias_bits-1:0] bias_next;
    logic                         use_local;

    // upper half of the counter picks local
    assign use_local  = bias[bp_pkg::bias_bits-1];
    assign pred_taken = use_local ? local_taken : global_taken;
    assign pred_pc    = use_local ? local_pc : global_pc;

    // only disagreements in correctness move the bias
    always_comb begin
        bias_next = bias;
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            if (resolve_valid[i]) begin
                if (local_correct[i] && !global_correct[i] && bias_next != bias_max) begin
                    bias_next = bias_next + 1'b1;
                end else if (global_correct[i] && !local_correct[i] && bias_next != '0) begin
                    bias_next = bias_next - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bias <= bp_pkg::bias_reset_value;
        end else begin
            bias <= bias_next;
        end
    end

    bias_no_wrap: assert property (
        @(posedge clock) disable iff (reset)
        ((bias == bias_max) |=> (bias != '0)) and ((bias == '0) |=> (bias != bias_max))
    ) else $error("chooser bias wrapped");

endmodule

//--- verilog/tournament_predictor.sv
`timescale 1ns/100ps

module tournament_predictor (
    input  logic                                    clock,
    input  logic                                    reset,
    input  bp_pkg::addr_t                           pc_start,
    input  logic          [bp_pkg::fetch_width-1:0] resolve_valid,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0] resolve_pc,
    input  logic          [bp_pkg::fetch_width-1:0] resolve_taken,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0] resolve_target,
    output logic          [bp_pkg::fetch_width-1:0] pred_taken,
    output bp_pkg::addr_t [bp_pkg::fetch_width-1:0] pred_pc
);

    logic          [bp_pkg::fetch_width-1:0] local_taken;
    bp_pkg::addr_t [bp_pkg::fetch_width-1:0] local_pc;
    logic          [bp_pkg::fetch_width-1:0] local_correct;
    logic          [bp_pkg::fetch_width-1:0] global_taken;
    bp_pkg::addr_t [bp_pkg::fetch_width-1:0] global_pc;
    logic          [bp_pkg::fetch_width-1:0] global_correct;

    local_predictor local_pred (
        .clock          (clock),
        .reset          (reset),
        .pc_start       (pc_start),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .slot_taken     (local_taken),
        .slot_pc        (local_pc),
        .correct        (local_correct)
    );

    gshare_predictor gshare_pred (
        .clock          (clock),
        .reset          (reset),
        .pc_start       (pc_start),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .slot_taken     (global_taken),
        .slot_pc        (global_pc),
        .correct        (global_correct)
    );

    predictor_chooser chooser (
        .clock          (clock),
        .reset          (reset),
        .resolve_valid  (resolve_valid),
        .local_taken    (local_taken),
        .local_pc       (local_pc),
        .local_correct  (local_correct),
        .global_taken   (global_taken),
        .global_pc      (global_pc),
        .global_correct (global_correct),
        .pred_taken     (pred_taken),
        .pred_pc        (pred_pc)
    );

endmodule

//--- sim/tournament_predictor_tb.sv
`timescale 1ns/100ps

module tournament_predictor_tb;

    localparam string vector_file = "sim/bp_vectors.txt";
    localparam int kind_test   = 0;
    localparam int kind_reset  = 1;
    localparam int kind_vector = 2;

    // ten hex fields per vector line with field 0 in the low word
    typedef logic [9:0][31:0] vector_t;

    logic                                    clock;
    logic                                    reset;
    bp_pkg::addr_t                           pc_start;
    logic          [bp_pkg::fetch_width-1:0] resolve_valid;
    bp_pkg::addr_t [bp_pkg::fetch_width-1:0] resolve_pc;
    logic          [bp_pkg::fetch_width-1:0] resolve_taken;
    bp_pkg::addr_t [bp_pkg::fetch_width-1:0] resolve_target;
    logic          [bp_pkg::fetch_width-1:0] pred_taken;
    bp_pkg::addr_t [bp_pkg::fetch_width-1:0] pred_pc;

    int      kind_q[$];
    string   name_q[$];
    vector_t vec_q[$];

    int    vector_count = 0;
    int    cycle_count  = 0;
    int    cycle_limit  = 0;
    int    error_count  = 0;
    int    check_count  = 0;
    int    test_count   = 0;
    int    test_errors  = 0;
    int    test_checks  = 0;
    string test_name    = "";

    tournament_predictor uut (
        .clock          (clock),
        .reset          (reset),
        .pc_start       (pc_start),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .pred_taken     (pred_taken),
        .pred_pc        (pred_pc)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // watchdog
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: the run went past %0d clock cycles", cycle_limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic string trim_line(input string text);
        string result;
        result = text;
        while (result.len() > 0 &&
               (result.getc(result.len() - 1) inside {8'd10, 8'd13, 8'd32})) begin
            result = result.substr(0, result.len() - 2);
        end
        return result;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] f [10];
        vector_t     v;
        fd = $fopen(vector_file, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", vector_file);
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            line = trim_line(line);
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            if (line.len() > 5 && line.substr(0, 4) == "test ") begin
                kind_q.push_back(kind_test);
                name_q.push_back(line.substr(5, line.len() - 1));
                vec_q.push_back('0);
            end else if (line == "reset") begin
                kind_q.push_back(kind_reset);
                name_q.push_back("");
                vec_q.push_back('0);
            end else begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                                 f[0], f[1], f[2], f[3], f[4],
                                 f[5], f[6], f[7], f[8], f[9]);
                if (fields != 10) begin
                    $display("could not read the vector line: %s", line);
                    error_count++;
                    continue;
                end
                for (int k = 0; k < 10; k++) begin
                    v[k] = f[k];
                end
                kind_q.push_back(kind_vector);
                name_q.push_back("");
                vec_q.push_back(v);
                vector_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_inputs();
        pc_start       = '0;
        resolve_valid  = '0;
        resolve_pc     = '0;
        resolve_taken  = '0;
        resolve_target = '0;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        idle_inputs();
        repeat (2) @(posedge clock);
        #10;
        reset = 1'b0;
    endtask

    task automatic check_outputs(
        input logic [bp_pkg::fetch_width-1:0] exp_taken,
        input bp_pkg::addr_t                  exp_pc0,
        input bp_pkg::addr_t                  exp_pc1
    );
        bp_pkg::addr_t exp_pc [2];
        exp_pc[0] = exp_pc0;
        exp_pc[1] = exp_pc1;
        check_count++;
        test_checks++;
        if (pred_taken !== exp_taken) begin
            $display("Mismatch at %0t: pred_taken expected %b, got %b",
                     $time, exp_taken, pred_taken);
            error_count++;
            test_errors++;
        end
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            if (pred_pc[i] !== exp_pc[i]) begin
                $display("Mismatch at %0t: pred_pc[%0d] expected %h, got %h",
                         $time, i, exp_pc[i], pred_pc[i]);
                error_count++;
                test_errors++;
            end
        end
    endtask

    // drive just after the edge, sample just before the next one
    task automatic run_vector(input vector_t v);
        @(posedge clock);
        #10;
        pc_start          = v[0];
        resolve_valid     = v[1][1:0];
        resolve_taken     = v[2][1:0];
        resolve_pc[0]     = v[3];
        resolve_target[0] = v[4];
        resolve_pc[1]     = v[5];
        resolve_target[1] = v[6];
        #80;
        check_outputs(v[7][1:0], v[8], v[9]);
    endtask

    // untrained high region where nothing can hit
    task automatic idle_cycle();
        bp_pkg::addr_t pc;
        pc = 32'h8000_0000 | ($urandom & 32'h0fff_fffc);
        @(posedge clock);
        #10;
        idle_inputs();
        pc_start = pc;
        #80;
        check_outputs('0, pc + 32'd4, pc + 32'd8);
    endtask

    task automatic finish_test();
        $display("test %s finished: %0d checks, %0d errors",
                 test_name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        void'($urandom(93420));
        reset = 1'b1;
        idle_inputs();
        load_vectors();
        cycle_limit = 2 * vector_count + 20;
        apply_reset();
        foreach (kind_q[k]) begin
            if (kind_q[k] == kind_test) begin
                if (test_count > 0) begin
                    finish_test();
                    idle_cycle();
                end
                test_name = name_q[k];
                test_count++;
            end else if (kind_q[k] == kind_reset) begin
                @(posedge clock);
                #10;
                apply_reset();
            end else begin
                run_vector(vec_q[k]);
            end
        end
        if (test_count > 0) begin
            finish_test();
        end
        if (vector_count == 0) begin
            $display("no vectors were loaded, nothing was checked");
            error_count++;
        end
        $display("done: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- sim/bp_vectors.txt
# columns: pc_start resolve_valid resolve_taken resolve_pc0 resolve_target0
#          resolve_pc1 resolve_target1 expected_taken expected_pc0 expected_pc1
# valid, taken and expected_taken are two-bit masks, bit 0 is slot 0
test reset_default
00001000 0 0 00000000 00000000 00000000 00000000 0 00001004 00001008
00001008 0 0 00000000 00000000 00000000 00000000 0 0000100c 00001010
test taken_branch
# branch at 1008 resolves taken to 2000
00001000 1 1 00001008 00002000 00000000 00000000 0 00001004 00001008
00001008 0 0 00000000 00000000 00000000 00000000 1 00002000 00002004
test tag_alias
# same btb index as 1008 but another tag
00003008 0 0 00000000 00000000 00000000 00000000 0 0000300c 00003010
test bias_to_gshare
# local wrong and gshare right twice, bias 3 to 1
00001008 3 0 00001014 00000000 0000101c 00000000 1 00002000 00002004
# gshare selected now
00001008 0 0 00000000 00000000 00000000 00000000 0 0000100c 00001010
# bias 1 to 0
00001008 1 0 00001008 00000000 00000000 00000000 0 0000100c 00001010
# saturates at 0
00001008 1 1 00001008 00002000 00000000 00000000 1 00002000 00002004
# both correct
00001008 1 0 00001014 00000000 00000000 00000000 0 0000100c 00001010
# only local correct, bias 0 to 1
00001008 1 1 00001008 00002000 00000000 00000000 0 0000100c 00001010
# bias 1 to 2
00001008 1 1 00001008 00002000 00000000 00000000 0 0000100c 00001010
# local selected again
00001008 0 0 00000000 00000000 00000000 00000000 1 00002000 00002004
test btb_collision
# both reports land on btb index 9
00001000 3 3 00004024 00006000 00005024 00007000 0 00001004 00001008
00005024 0 0 00000000 00000000 00000000 00000000 1 00007000 00007004
00004024 0 0 00000000 00000000 00000000 00000000 0 00004028 0000402c
test second_reset
reset
00001008 0 0 00000000 00000000 00000000 00000000 0 0000100c 00001010
00005024 0 0 00000000 00000000 00000000 00000000 0 00005028 0000502c
00001000 0 0 00000000 00000000 00000000 00000000 0 00001004 00001008

//--- filelist.f
verilog/bp_pkg.sv
verilog/btb.sv
verilog/local_predictor.sv
verilog/gshare_predictor.sv
verilog/predictor_chooser.sv
verilog/tournament_predictor.sv
sim/tournament_predictor_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tournament_predictor_tb -f filelist.f -o tb_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
